// File: hw/link_pkg.sv
/* Link bridge package
   Widths, flit and PHY frame structs, debug status bit positions */

package link_pkg;

  ////////////////////
  // Widths

  // Flit payload, reduced from the full 512-bit LPIF data bus
  localparam int data_width = 64;
  // One PHY channel
  localparam int phy_width = 48;
  // Marker userbits carried next to the strobe
  localparam int marker_width = 4;
  // state + protid + data + dvalid + crc + crc_valid + valid
  localparam int flit_width = 89;

  ////////////////////
  // LPIF flit

  typedef struct packed {
    logic [3:0]            state;
    logic [1:0]            protid;
    logic [data_width-1:0] data;
    logic                  dvalid;
    logic [15:0]           crc;
    logic                  crc_valid;
    logic                  valid;
  } lpif_flit_t;

  ////////////////////
  // PHY frame across both channels

  // Flit sits in the low bits, strobe and marker land in channel 1
  // Spare pads the frame out to two full channels
  typedef struct packed {
    logic [2*phy_width-flit_width-marker_width-2:0] spare;
    logic [marker_width-1:0]                        marker;
    logic                                           strobe;
    lpif_flit_t                                     flit;
  } phy_frame_t;

  ////////////////////
  // Debug status word

  // Remaining bits of the 32-bit word read as zero
  localparam int debug_tx_online_bit = 19;
  localparam int debug_rx_online_bit = 18;
  localparam int debug_rx_locked_bit = 17;

endpackage

// File: hw/link_auto_sync.sv
/* Auto sync block
   Online delay counters, periodic strobe generator, persistent marker */

`timescale 1ns/100ps

module link_auto_sync (
  input  logic                              clk_wr,
  input  logic                              rst_n,
  input  logic                              tx_online,
  input  logic                              rx_online,
  input  logic [15:0]                       delay_x_value,
  input  logic [15:0]                       delay_y_value,
  input  logic [15:0]                       delay_z_value,
  input  logic [link_pkg::marker_width-1:0] tx_mrk_userbit,
  input  logic                              tx_stb_userbit,
  output logic                              tx_online_delay,
  output logic                              rx_online_delay,
  output logic                              tx_auto_stb_userbit,
  output logic [link_pkg::marker_width-1:0] tx_auto_mrk_userbit
);

  logic [15:0] tx_cnt;
  logic [15:0] rx_cnt;
  logic [15:0] stb_cnt;
  logic        tx_rise;
  logic        rx_src;
  logic        stb_pulse;

  // Cycle in which the delayed tx flag gets set
  assign tx_rise = tx_online && !tx_online_delay && (tx_cnt == 16'd0);

  // Receive side only counts once transmit is fully up
  // Including tx_online drops both flags on the same edge
  assign rx_src = rx_online && tx_online && tx_online_delay;

  ////////////////////
  // Transmit online delay

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_online_delay <= 1'b0;
      tx_cnt          <= delay_x_value;
    end else if (!tx_online) begin
      // Reload while offline, count starts on first high sample
      tx_online_delay <= 1'b0;
      tx_cnt          <= delay_x_value;
    end else if (tx_rise) begin
      tx_online_delay <= 1'b1;
    end else if (!tx_online_delay) begin
      tx_cnt <= tx_cnt - 16'd1;
    end
  end

  ////////////////////
  // Receive online delay

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_online_delay <= 1'b0;
      rx_cnt          <= delay_y_value;
    end else if (!rx_src) begin
      rx_online_delay <= 1'b0;
      rx_cnt          <= delay_y_value;
    end else if (rx_cnt <= 16'd1) begin
      // Counted from the tx flag rising, so 0 and 1 both give one cycle
      rx_online_delay <= 1'b1;
    end else begin
      rx_cnt <= rx_cnt - 16'd1;
    end
  end

  ////////////////////
  // Strobe generator

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      stb_pulse <= 1'b0;
      stb_cnt   <= 16'd0;
    end else if (!tx_online) begin
      stb_pulse <= 1'b0;
      stb_cnt   <= 16'd0;
    end else if (tx_rise || tx_online_delay) begin
      // Counter sits at zero before the rise, so first pulse lines up with it
      if (stb_cnt == 16'd0) begin
        stb_pulse <= 1'b1;
        stb_cnt   <= delay_z_value - 16'd1;
      end else begin
        stb_pulse <= 1'b0;
        stb_cnt   <= stb_cnt - 16'd1;
      end
    end else begin
      stb_pulse <= 1'b0;
    end
  end

  // User strobe still gets through
  assign tx_auto_stb_userbit = stb_pulse | tx_stb_userbit;

  // Marker held for as long as transmit is up
  assign tx_auto_mrk_userbit = tx_online_delay ? tx_mrk_userbit : '0;

  // Receive never comes up ahead of transmit
  a_rx_after_tx: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_online_delay |-> tx_online_delay);

endmodule

// File: hw/link_user_if.sv
/* User side interface
   Upstream flit to PHY path, registered and qualified downstream flit */

`timescale 1ns/100ps

module link_user_if (
  input  logic                 clk_wr,
  input  logic                 rst_n,

  // User side
  input  link_pkg::lpif_flit_t ustrm_flit,
  output link_pkg::lpif_flit_t dstrm_flit,

  // PHY side
  output link_pkg::lpif_flit_t tx_flit,
  input  link_pkg::lpif_flit_t rx_flit,
  input  logic                 rx_locked
);

  link_pkg::lpif_flit_t rx_flit_masked;

  ////////////////////
  // Upstream

  // No FIFO or credits in this path
  // Flit goes straight to the frame builder in the same cycle
  assign tx_flit = ustrm_flit;

  ////////////////////
  // Downstream

  // Qualifiers only trusted once strobe alignment is found
  // Payload fields pass untouched so they stay visible for debug
  always_comb begin
    rx_flit_masked = rx_flit;
    if (!rx_locked) begin
      rx_flit_masked.valid     = 1'b0;
      rx_flit_masked.dvalid    = 1'b0;
      rx_flit_masked.crc_valid = 1'b0;
    end
  end

  // One register stage towards the user
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      dstrm_flit <= '0;
    end else begin
      dstrm_flit <= rx_flit_masked;
    end
  end

  ////////////////////
  // Checks

  // A valid flit downstream needs lock on the cycle it was captured
  a_valid_needs_lock: assert property (@(posedge clk_wr) disable iff (!rst_n)
    dstrm_flit.valid |-> $past(rx_locked));

endmodule

// File: hw/link_phy_concat.sv
/* PHY concatenation
   Transmit frame build and channel split, receive join and strobe lock */

`timescale 1ns/100ps

module link_phy_concat (
  input  logic                              clk_wr,
  input  logic                              rst_n,

  // From auto sync
  input  logic                              tx_online_delay,
  input  logic                              rx_online_delay,
  input  logic                              tx_auto_stb_userbit,
  input  logic [link_pkg::marker_width-1:0] tx_auto_mrk_userbit,

  // Flit side
  input  link_pkg::lpif_flit_t              tx_flit,
  output link_pkg::lpif_flit_t              rx_flit,
  output logic                              rx_locked,

  // PHY channels
  output logic [link_pkg::phy_width-1:0]    tx_phy0,
  output logic [link_pkg::phy_width-1:0]    tx_phy1,
  input  logic [link_pkg::phy_width-1:0]    rx_phy0,
  input  logic [link_pkg::phy_width-1:0]    rx_phy1
);

  link_pkg::phy_frame_t tx_frame;
  link_pkg::phy_frame_t tx_frame_q;
  link_pkg::phy_frame_t rx_frame_q;

  ////////////////////
  // Transmit

  // Frame assembly, spare bits stay at zero
  always_comb begin
    tx_frame        = '0;
    tx_frame.flit   = tx_flit;
    tx_frame.strobe = tx_auto_stb_userbit;
    tx_frame.marker = tx_auto_mrk_userbit;
  end

  // Channels idle at zero until transmit is up
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_frame_q <= '0;
    end else if (!tx_online_delay) begin
      tx_frame_q <= '0;
    end else begin
      tx_frame_q <= tx_frame;
    end
  end

  // Low half on channel 0
  assign tx_phy0 = tx_frame_q[link_pkg::phy_width-1:0];
  // High half, with strobe and marker, on channel 1
  assign tx_phy1 = tx_frame_q[2*link_pkg::phy_width-1:link_pkg::phy_width];

  ////////////////////
  // Receive

  // Channels rejoined in the same order they were split
  always_ff @(posedge clk_wr) begin
    rx_frame_q <= {rx_phy1, rx_phy0};
  end

  assign rx_flit = rx_frame_q.flit;

  ////////////////////
  // Strobe lock

  // Sticky once a strobe is seen with receive online
  // Dropped as soon as receive goes offline
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_locked <= 1'b0;
    end else if (!rx_online_delay) begin
      rx_locked <= 1'b0;
    end else if (rx_frame_q.strobe) begin
      rx_locked <= 1'b1;
    end
  end

  ////////////////////
  // Checks

  // Padding on the wire never carries anything
  a_tx_spare_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_frame_q.spare == '0);

endmodule

// File: hw/link_slave_top.sv
/* Link bridge slave top
   Auto sync, user interface and PHY concatenation, debug status */

`timescale 1ns/100ps

module link_slave_top (
  input  logic                              clk_wr,
  input  logic                              rst_n,

  // Control and configuration
  input  logic                              tx_online,
  input  logic                              rx_online,
  input  logic [link_pkg::marker_width-1:0] tx_mrk_userbit,
  input  logic                              tx_stb_userbit,
  input  logic [15:0]                       delay_x_value,
  input  logic [15:0]                       delay_y_value,
  input  logic [15:0]                       delay_z_value,

  // User side
  input  link_pkg::lpif_flit_t              ustrm_flit,
  output link_pkg::lpif_flit_t              dstrm_flit,

  // PHY channels
  output logic [link_pkg::phy_width-1:0]    tx_phy0,
  output logic [link_pkg::phy_width-1:0]    tx_phy1,
  input  logic [link_pkg::phy_width-1:0]    rx_phy0,
  input  logic [link_pkg::phy_width-1:0]    rx_phy1,

  // Debug
  output logic [31:0]                       debug_status
);

  ////////////////////
  // Interconnect

  link_pkg::lpif_flit_t              tx_flit;
  link_pkg::lpif_flit_t              rx_flit;
  logic                              rx_locked;
  logic                              tx_online_delay;
  logic                              rx_online_delay;
  logic                              tx_auto_stb_userbit;
  logic [link_pkg::marker_width-1:0] tx_auto_mrk_userbit;

  ////////////////////
  // Blocks

  link_auto_sync i_link_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  link_user_if i_link_user_if (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .ustrm_flit (ustrm_flit),
    .dstrm_flit (dstrm_flit),
    .tx_flit    (tx_flit),
    .rx_flit    (rx_flit),
    .rx_locked  (rx_locked)
  );

  link_phy_concat i_link_phy_concat (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_flit             (tx_flit),
    .rx_flit             (rx_flit),
    .rx_locked           (rx_locked),
    .tx_phy0             (tx_phy0),
    .tx_phy1             (tx_phy1),
    .rx_phy0             (rx_phy0),
    .rx_phy1             (rx_phy1)
  );

  ////////////////////
  // Debug status

  // Flags wired straight to their bit positions, rest tied low
  always_comb begin
    debug_status = '0;
    debug_status[link_pkg::debug_tx_online_bit] = tx_online_delay;
    debug_status[link_pkg::debug_rx_online_bit] = rx_online_delay;
    debug_status[link_pkg::debug_rx_locked_bit] = rx_locked;
  end

endmodule

// File: testbench/link_tb_checks.svh
/* Testbench helpers
   Value check, status bit wait with timeout, expected downstream flit */

`ifndef LINK_TB_CHECKS_SVH
`define LINK_TB_CHECKS_SVH

////////////////////
// Checks

// Any mismatch ends the run
task automatic check_value(input string what, input logic [127:0] actual,
                           input logic [127:0] expected);
  if (actual !== expected) begin
    $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
    $display("Regression failed");
    $fatal(1, "value mismatch");
  end
endtask

// Polls one debug status bit on the falling edge
// Returns the number of cycles it took to reach the level
task automatic wait_status_bit(input int bit_pos, input logic level, input string what,
                               input int limit, output int cycles);
  int count;
  count = 0;
  while (debug_status[bit_pos] !== level && count < limit) begin
    @(negedge clk);
    count++;
  end
  cycles = count;
  if (debug_status[bit_pos] !== level) begin
    $display("Timeout: %s did not happen within %0d cycles", what, limit);
    $display("Regression failed");
    $fatal(1, "wait timeout");
  end
endtask

////////////////////
// Reference model

// Qualifiers pass only with lock, payload always passes
function automatic link_pkg::lpif_flit_t expected_flit(input link_pkg::lpif_flit_t sent,
                                                       input logic locked);
  link_pkg::lpif_flit_t exp_flit;
  exp_flit = sent;
  if (!locked) begin
    exp_flit.valid     = 1'b0;
    exp_flit.dvalid    = 1'b0;
    exp_flit.crc_valid = 1'b0;
  end
  return exp_flit;
endfunction

`endif

// File: testbench/link_tb.sv
/* Link bridge slave testbench
   Clock, reset, PHY loopback, stimulus, reference queue and downstream compare */

`timescale 1ns/100ps

module link_tb;

  localparam logic [15:0] dly_x = 16'd7;
  localparam logic [15:0] dly_y = 16'd5;
  localparam logic [15:0] dly_z = 16'd6;
  localparam logic [link_pkg::marker_width-1:0] marker_value = 4'ha;
  // Strobe and marker positions inside channel 1
  localparam int strobe_pos = link_pkg::flit_width - link_pkg::phy_width;
  localparam int marker_pos = strobe_pos + 1;
  localparam int wait_limit = 200;

  logic                              clk;
  logic                              rst_n;
  logic                              tx_online;
  logic                              rx_online;
  logic [link_pkg::marker_width-1:0] tx_mrk_userbit;
  logic                              tx_stb_userbit;
  logic [15:0]                       delay_x_value;
  logic [15:0]                       delay_y_value;
  logic [15:0]                       delay_z_value;
  link_pkg::lpif_flit_t              ustrm_flit;
  link_pkg::lpif_flit_t              dstrm_flit;
  logic [link_pkg::phy_width-1:0]    tx_phy0;
  logic [link_pkg::phy_width-1:0]    tx_phy1;
  logic [link_pkg::phy_width-1:0]    rx_phy0;
  logic [link_pkg::phy_width-1:0]    rx_phy1;
  logic [31:0]                       debug_status;

  integer               seed;
  // Model state
  link_pkg::lpif_flit_t wire_q[$];
  logic                 lock_prev;
  logic                 tx_up_prev;
  int                   locked_checks;
  int                   masked_checks;

  `include "link_tb_checks.svh"

  // PHY loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  always #5 clk = ~clk;

  // Clock goes to clk_wr, the rest match the top level ports by name
  link_slave_top i_link_slave_top (
    .clk_wr (clk),
    .*
  );

  ////////////////////
  // Stimulus helpers

  task automatic make_flit(input logic qual_high, output link_pkg::lpif_flit_t flit);
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    logic [31:0] r_ctl;
    r_hi = $random(seed);
    r_lo = $random(seed);
    r_ctl = $random(seed);
    flit.data      = {r_hi, r_lo};
    flit.state     = r_ctl[3:0];
    flit.protid    = r_ctl[5:4];
    flit.crc       = r_ctl[21:6];
    flit.dvalid    = r_ctl[22] | qual_high;
    flit.crc_valid = r_ctl[23] | qual_high;
    flit.valid     = r_ctl[24] | qual_high;
  endtask

  task automatic drive_flits(input int count, input logic qual_high);
    link_pkg::lpif_flit_t flit;
    repeat (count) begin
      @(negedge clk);
      make_flit(qual_high, flit);
      ustrm_flit = flit;
    end
  endtask

  // Cycles up to the next strobe on channel 1, marker checked on the way
  task automatic next_strobe(output int gap);
    link_pkg::lpif_flit_t flit;
    int   count;
    logic seen;
    count = 0;
    seen = 1'b0;
    while (!seen && count < wait_limit) begin
      @(negedge clk);
      count++;
      seen = (tx_phy1[strobe_pos] === 1'b1);
      check_value("tx_phy1 marker", 128'(tx_phy1[marker_pos +: link_pkg::marker_width]),
                  128'(marker_value));
      make_flit(1'b1, flit);
      ustrm_flit = flit;
    end
    gap = count;
    if (!seen) begin
      $display("Timeout: no strobe on tx_phy1 within %0d cycles", wait_limit);
      $display("Regression failed");
      $fatal(1, "strobe timeout");
    end
  endtask

  task automatic compare_flit(input link_pkg::lpif_flit_t act, input link_pkg::lpif_flit_t exp);
    check_value("dstrm_flit.state", 128'(act.state), 128'(exp.state));
    check_value("dstrm_flit.protid", 128'(act.protid), 128'(exp.protid));
    check_value("dstrm_flit.data", 128'(act.data), 128'(exp.data));
    check_value("dstrm_flit.dvalid", 128'(act.dvalid), 128'(exp.dvalid));
    check_value("dstrm_flit.crc", 128'(act.crc), 128'(exp.crc));
    check_value("dstrm_flit.crc_valid", 128'(act.crc_valid), 128'(exp.crc_valid));
    check_value("dstrm_flit.valid", 128'(act.valid), 128'(exp.valid));
  endtask

  ////////////////////
  // Reference and compare

  // Flit taken by the transmit register each edge, zero while transmit is down
  always @(posedge clk) begin
    if (!rst_n) begin
      wire_q.delete();
    end else if (tx_up_prev) begin
      wire_q.push_back(ustrm_flit);
    end else begin
      wire_q.push_back('0);
    end
  end

  // Downstream flit lags the transmit register by two edges
  // Masking follows the lock state one cycle back
  always @(negedge clk) begin
    link_pkg::lpif_flit_t sent;
    if (wire_q.size() == 3) begin
      sent = wire_q.pop_front();
      compare_flit(dstrm_flit, expected_flit(sent, lock_prev));
      if (lock_prev) begin
        locked_checks++;
      end else if (sent.valid || sent.dvalid || sent.crc_valid) begin
        masked_checks++;
      end
    end
    lock_prev = debug_status[link_pkg::debug_rx_locked_bit];
    tx_up_prev = debug_status[link_pkg::debug_tx_online_bit];
  end

  ////////////////////
  // Sequence

  initial begin
    int cycles;
    int gap;
    int locked_before;
    int masked_before;
    clk = 1'b0;
    rst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    tx_mrk_userbit = marker_value;
    tx_stb_userbit = 1'b0;
    delay_x_value = dly_x;
    delay_y_value = dly_y;
    delay_z_value = dly_z;
    ustrm_flit = '0;
    seed = 32'h00eda2e1;
    lock_prev = 1'b0;
    tx_up_prev = 1'b0;
    locked_checks = 0;
    masked_checks = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Offline, link stays quiet whatever the user drives
    repeat (50) begin
      drive_flits(1, 1'b1);
      check_value("tx_phy0 offline", 128'(tx_phy0), 128'd0);
      check_value("tx_phy1 offline", 128'(tx_phy1), 128'd0);
      check_value("dstrm_flit offline", 128'(dstrm_flit), 128'd0);
      check_value("debug_status offline", 128'(debug_status), 128'd0);
    end

    // Online delays, counted from the first edge that samples tx_online
    @(negedge clk);
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_status_bit(link_pkg::debug_tx_online_bit, 1'b1, "transmit online flag",
                    wait_limit, cycles);
    check_value("tx online delay", 128'(cycles), 128'(dly_x) + 128'd1);
    wait_status_bit(link_pkg::debug_rx_online_bit, 1'b1, "receive online flag",
                    wait_limit, cycles);
    check_value("rx online delay", 128'(cycles), 128'(dly_y));

    // Strobe period, first call only lines up with a pulse
    next_strobe(gap);
    repeat (4) begin
      next_strobe(gap);
      check_value("strobe period", 128'(gap), 128'(dly_z));
    end

    // Locked loopback
    wait_status_bit(link_pkg::debug_rx_locked_bit, 1'b1, "receive lock", wait_limit, cycles);
    locked_before = locked_checks;
    drive_flits(200, 1'b0);
    repeat (4) @(negedge clk);
    // Each of the 200 flits must have been compared with lock held
    check_value("locked flits compared", 128'(locked_checks - locked_before >= 200), 128'd1);

    // Receive dropped, lock clears and qualifiers get masked again
    @(negedge clk);
    rx_online = 1'b0;
    wait_status_bit(link_pkg::debug_rx_locked_bit, 1'b0, "lock release", 4, cycles);
    check_value("rx online flag after drop",
                128'(debug_status[link_pkg::debug_rx_online_bit]), 128'd0);
    masked_before = masked_checks;
    drive_flits(20, 1'b1);
    repeat (4) @(negedge clk);
    check_value("masked flits after drop", 128'(masked_checks - masked_before >= 20), 128'd1);

    $display("Regression passed");
    $finish;
  end

endmodule

// File: project.f
+incdir+testbench
hw/link_pkg.sv
hw/link_auto_sync.sv
hw/link_user_if.sv
hw/link_phy_concat.sv
hw/link_slave_top.sv
testbench/link_tb.sv

// File: Makefile
# Verilator build and run of the link bridge slave testbench

VERILATOR ?= verilator
TOP       ?= link_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
